//--- tb/dataMemoryTestdata.txt
// write size addr wdata expected, all hex, one access per cycle
// size 0 word, 1 half, 2 byte, 3 reserved; expected is checked on reads only
0 0 0000 00000000 00000000
0 0 0004 00000000 00000000
0 0 1230 00000000 00000000
0 0 3ffc 00000000 00000000
1 0 0010 8a3c7fe1 00000000
0 0 0010 00000000 8a3c7fe1
0 2 0010 00000000 ffffffe1
0 2 0011 00000000 0000007f
0 2 0012 00000000 0000003c
0 2 0013 00000000 ffffff8a
1 0 0020 11223344 00000000
1 1 0020 0000c5a7 00000000
0 0 0020 00000000 1122c5a7
1 1 0022 ffff3b90 00000000
0 0 0020 00000000 3b90c5a7
0 1 0020 00000000 ffffc5a7
0 1 0022 00000000 00003b90
1 0 0100 a5a5a5a5 00000000
1 2 0100 12345601 00000000
0 0 0100 00000000 a5a5a501
1 2 0101 000000f2 00000000
0 0 0100 00000000 a5a5f201
1 2 0102 00000073 00000000
0 0 0100 00000000 a573f201
1 2 0103 0000009c 00000000
0 0 0100 00000000 9c73f201
1 3 0100 ffffffff 00000000
0 0 0100 00000000 9c73f201
0 3 0100 00000000 00000000
0 1 0021 00000000 ffffc5a7
0 1 0023 00000000 00003b90
1 1 0023 0000807f 00000000
0 0 0020 00000000 807fc5a7
1 1 0021 00001234 00000000
0 0 0020 00000000 807f1234

//--- flist.f
logic/dataMemPkg.sv
logic/storeAligner.sv
logic/byteLaneRam.sv
logic/loadExtractor.sv
logic/dataMemory.sv
tb/dataMemoryTb.sv

//--- Makefile
# Verilator build and run for the data memory testbench

VERILATOR ?= verilator
TOP       ?= dataMemoryTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- tb/dataMemoryTb.sv
module dataMemoryTb;

    //////////////////////////////////////////////////
    // Settings of the run
    //////////////////////////////////////////////////

    localparam int addrBits     = dataMemPkg::defaultWordAddrWidth + dataMemPkg::offsetWidth;
    localparam int maxLines     = 200;
    localparam int resetTimeout = 20;
    localparam string testFile  = "tb/dataMemoryTestdata.txt";

    logic                                 clk;
    logic                                 reset;
    logic                                 memWrite;
    dataMemPkg::memOp                     op;
    logic [addrBits-1:0]                  addr;
    logic [dataMemPkg::dataWidth-1:0]     writeData;
    logic [dataMemPkg::dataWidth-1:0]     readData;

    dataMemory #(
        .wordAddrWidth (dataMemPkg::defaultWordAddrWidth)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .memWrite  (memWrite),
        .op        (op),
        .addr      (addr),
        .writeData (writeData),
        .readData  (readData)
    );

    //////////////////////////////////////////////////
    // Clock and reset
    //////////////////////////////////////////////////

    initial clk = 1'b0;
    always #4 clk = ~clk;

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkReadData(input logic [dataMemPkg::dataWidth-1:0] expected);
        if (readData !== expected) begin
            abortRun($sformatf("Mismatch at time %0t: readData expected %h, actual %h",
                $time, expected, readData));
        end
    endtask

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        while (reset !== 1'b0) begin
            @(posedge clk);
            cycles++;
            if (cycles > resetTimeout) begin
                abortRun($sformatf("reset was still high after %0d cycles", resetTimeout));
            end
        end
    endtask

    // Comment and blank lines carry no access
    function automatic bit isDataLine(input string text);
        byte first;
        if (text.len() == 0) begin
            return 1'b0;
        end
        first = text.getc(0);
        return !(first == "/" || first == "\n" || first == "\r");
    endfunction

    // One access per cycle, checked at the falling edge
    task automatic applyAccess(
        input logic                               wantWrite,
        input logic [1:0]                         sizeCode,
        input logic [addrBits-1:0]                byteAddr,
        input logic [dataMemPkg::dataWidth-1:0]   wordIn,
        input logic [dataMemPkg::dataWidth-1:0]   expected
    );
        @(posedge clk);
        memWrite  <= wantWrite;
        op        <= dataMemPkg::memOp'(sizeCode);
        addr      <= byteAddr;
        writeData <= wordIn;
        @(negedge clk);
        if (!wantWrite) begin
            checkReadData(expected);
        end
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        int          fd;
        int          fields;
        int          lineNo;
        int          accessCount;
        bit          done;
        string       line;
        logic [31:0] wField;
        logic [31:0] sizeField;
        logic [31:0] addrField;
        logic [31:0] dataField;
        logic [31:0] expField;

        memWrite  = 1'b0;
        op        = dataMemPkg::opWord;
        addr      = '0;
        writeData = '0;

        fd = $fopen(testFile, "r");
        if (fd == 0) begin
            abortRun($sformatf("could not open the test data file %s", testFile));
        end

        waitResetRelease();

        done        = 1'b0;
        lineNo      = 0;
        accessCount = 0;
        while (!done) begin
            if ($fgets(line, fd) == 0) begin
                done = 1'b1;
            end else begin
                lineNo++;
                if (lineNo > maxLines) begin
                    abortRun($sformatf("test data file is longer than %0d lines", maxLines));
                end
                if (isDataLine(line)) begin
                    fields = $sscanf(line, "%h %h %h %h %h",
                        wField, sizeField, addrField, dataField, expField);
                    if (fields != 5) begin
                        abortRun($sformatf("line %0d of the test data file is malformed",
                            lineNo));
                    end
                    accessCount++;
                    applyAccess(wField[0], sizeField[1:0], addrField[addrBits-1:0],
                        dataField, expField);
                end
            end
        end
        $fclose(fd);

        // Strobe back to idle
        @(posedge clk);
        memWrite <= 1'b0;

        if (accessCount == 0) begin
            abortRun("the test data file holds no accesses");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- logic/dataMemory.sv
module dataMemory #(
    parameter int wordAddrWidth = dataMemPkg::defaultWordAddrWidth
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      memWrite,
    input  dataMemPkg::memOp                          op,
    input  logic [wordAddrWidth+1:0]                  addr,
    input  logic [dataMemPkg::dataWidth-1:0]          writeData,
    output logic [dataMemPkg::dataWidth-1:0]          readData
);

    //////////////////////////////////////////////////
    // Address split
    //////////////////////////////////////////////////

    logic [wordAddrWidth-1:0]               wordAddr;
    logic [dataMemPkg::offsetWidth-1:0]     offset;

    assign wordAddr = addr[wordAddrWidth+1:dataMemPkg::offsetWidth];
    assign offset   = addr[dataMemPkg::offsetWidth-1:0];

    // Lane side buses
    logic [dataMemPkg::laneCount-1:0]       laneWrite;
    logic [dataMemPkg::dataWidth-1:0]       laneData;
    logic [dataMemPkg::dataWidth-1:0]       laneRead;

    //////////////////////////////////////////////////
    // Store path
    //////////////////////////////////////////////////

    storeAligner aligner (
        .memWrite  (memWrite),
        .op        (op),
        .offset    (offset),
        .writeData (writeData),
        .laneWrite (laneWrite),
        .laneData  (laneData)
    );

    //////////////////////////////////////////////////
    // Byte lanes
    //////////////////////////////////////////////////

    for (genvar lane = 0; lane < dataMemPkg::laneCount; lane++) begin : gLane
        byteLaneRam #(
            .wordAddrWidth (wordAddrWidth)
        ) laneRam (
            .clk       (clk),
            .reset     (reset),
            .write     (laneWrite[lane]),
            .wordAddr  (wordAddr),
            .writeByte (laneData[lane*dataMemPkg::laneWidth +: dataMemPkg::laneWidth]),
            .readByte  (laneRead[lane*dataMemPkg::laneWidth +: dataMemPkg::laneWidth])
        );
    end

    //////////////////////////////////////////////////
    // Load path
    //////////////////////////////////////////////////

    loadExtractor extractor (
        .op       (op),
        .offset   (offset),
        .laneRead (laneRead),
        .readData (readData)
    );

endmodule

//--- logic/loadExtractor.sv
module loadExtractor (
    input  dataMemPkg::memOp                          op,
    input  logic [dataMemPkg::offsetWidth-1:0]        offset,
    input  logic [dataMemPkg::dataWidth-1:0]          laneRead,
    output logic [dataMemPkg::dataWidth-1:0]          readData
);

    localparam int byteExt = dataMemPkg::dataWidth - dataMemPkg::laneWidth;
    localparam int halfExt = dataMemPkg::dataWidth - dataMemPkg::halfWidth;

    // Addressed pieces of the word
    logic [dataMemPkg::laneWidth-1:0] pickedByte;
    logic [dataMemPkg::halfWidth-1:0] pickedHalf;

    //////////////////////////////////////////////////
    // Lane select
    //////////////////////////////////////////////////

    // Byte uses both offset bits
    assign pickedByte = laneRead[offset * dataMemPkg::laneWidth +: dataMemPkg::laneWidth];

    // Halfword ignores offset bit 0
    assign pickedHalf = offset[1]
        ? laneRead[dataMemPkg::dataWidth-1:dataMemPkg::halfWidth]
        : laneRead[dataMemPkg::halfWidth-1:0];

    //////////////////////////////////////////////////
    // Sign extension
    //////////////////////////////////////////////////

    always_comb begin
        case (op)
            dataMemPkg::opWord: begin
                readData = laneRead;
            end
            dataMemPkg::opHalf: begin
                readData = {{halfExt{pickedHalf[dataMemPkg::halfWidth-1]}}, pickedHalf};
            end
            dataMemPkg::opByte: begin
                readData = {{byteExt{pickedByte[dataMemPkg::laneWidth-1]}}, pickedByte};
            end
            default: begin
                // Reserved size reads as zero
                readData = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Load path is purely combinational, so a bad size shows up directly
    always_comb begin
        opKnown: assert final (!$isunknown(op))
            else $error("access size unknown");
    end

endmodule

//--- logic/byteLaneRam.sv
module byteLaneRam #(
    parameter int wordAddrWidth = dataMemPkg::defaultWordAddrWidth
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 write,
    input  logic [wordAddrWidth-1:0]             wordAddr,
    input  logic [dataMemPkg::laneWidth-1:0]     writeByte,
    output logic [dataMemPkg::laneWidth-1:0]     readByte
);

    localparam int depth = 2 ** wordAddrWidth;

    // One byte per word of the memory
    logic [dataMemPkg::laneWidth-1:0] mem [depth];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            // Whole lane cleared in a single edge
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (write) begin
            mem[wordAddr] <= writeByte;
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // Asynchronous read, old data until the edge
    assign readByte = mem[wordAddr];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // An X strobe from the aligner would corrupt the lane silently
    writeKnown: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(write)
    ) else $error("lane write strobe unknown");

endmodule

//--- logic/storeAligner.sv
module storeAligner (
    input  logic                                                   memWrite,
    input  dataMemPkg::memOp                                       op,
    input  logic [dataMemPkg::offsetWidth-1:0]                     offset,
    input  logic [dataMemPkg::dataWidth-1:0]                       writeData,
    output logic [dataMemPkg::laneCount-1:0]                       laneWrite,
    output logic [dataMemPkg::dataWidth-1:0]                       laneData
);

    //////////////////////////////////////////////////
    // Lane masks
    //////////////////////////////////////////////////

    localparam logic [dataMemPkg::laneCount-1:0] lowPair  = 4'b0011;
    localparam logic [dataMemPkg::laneCount-1:0] highPair = 4'b1100;
    localparam logic [dataMemPkg::laneCount-1:0] oneLane  = 4'b0001;

    // Enables before the store strobe is applied
    logic [dataMemPkg::laneCount-1:0] sizeMask;

    //////////////////////////////////////////////////
    // Data replication and lane select
    //////////////////////////////////////////////////

    always_comb begin
        sizeMask = '0;
        laneData = writeData;
        case (op)
            dataMemPkg::opWord: begin
                sizeMask = '1;
                laneData = writeData;
            end
            dataMemPkg::opHalf: begin
                // Same halfword on both pairs
                laneData = {2{writeData[dataMemPkg::halfWidth-1:0]}};
                // Offset bit 1 picks the enabled pair
                sizeMask = offset[1] ? highPair : lowPair;
            end
            dataMemPkg::opByte: begin
                laneData = {dataMemPkg::laneCount{writeData[dataMemPkg::laneWidth-1:0]}};
                sizeMask = oneLane << offset;
            end
            default: begin
                // opNone leaves every lane untouched
                sizeMask = '0;
            end
        endcase
    end

    assign laneWrite = memWrite ? sizeMask : '0;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // A byte store must never spill into a neighbouring lane or carry an unknown enable
    always_comb begin
        byteStoreOneLane: assert final (op != dataMemPkg::opByte
            || ($onehot0(laneWrite) && !$isunknown(laneWrite)))
            else $error("byte store enables %b", laneWrite);
    end

endmodule

//--- logic/dataMemPkg.sv
package dataMemPkg;

    //////////////////////////////////////////////////
    // Access size
    //////////////////////////////////////////////////

    // Size code driven with every access
    typedef enum logic [1:0] {
        opWord = 2'd0,
        opHalf = 2'd1,
        opByte = 2'd2,
        // Reserved code, no write and zero on read
        opNone = 2'd3
    } memOp;

    //////////////////////////////////////////////////
    // Lane geometry
    //////////////////////////////////////////////////

    // Four byte lanes make up one bus word
    localparam int laneCount = 4;
    localparam int laneWidth = 8;
    localparam int dataWidth = laneCount * laneWidth;

    // Halfword spans two lanes
    localparam int halfWidth = 2 * laneWidth;

    //////////////////////////////////////////////////
    // Depth
    //////////////////////////////////////////////////

    // 4096 words by default
    localparam int defaultWordAddrWidth = 12;

    // Byte offset bits inside a word
    localparam int offsetWidth = 2;

endpackage
